/* tartaruga_fetch.f */
+incdir+include
verilog/tartaruga_pkg.sv
verilog/imem_req_if.sv
verilog/imem_wrapper.sv
verilog/fetch_line_buffer.sv
verilog/fetch_pc_gen.sv
verilog/tartaruga_fetch_top.sv
sim/tb_fetch_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_top -f tartaruga_fetch.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_fetch_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The verdict comes from the testbench output only.
if printf '%s\n' "$out" | grep -Fxq "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* sim/tb_fetch_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Fetch front end testbench
// Redirects, back-pressure and refills, checked by assertions
// against the memory fill rule.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "tartaruga_defines.svh"

module tb_fetch_top
    import tartaruga_pkg::*;
();

    localparam bus32_t MEM_BYTES = `IMEM_POS * 4;

    logic   clk;
    logic   rstn;
    logic   redirect_i;
    bus32_t redirect_pc_i;
    logic   instr_valid_o;
    logic   instr_ready_i;
    bus32_t instr_pc_o;
    bus32_t instr_o;

    bus32_t exp_pc;                                  // Pc of the next accepted instruction.
    logic   seen_redirect;
    logic   random_ready = 1'b0;
    int     accept_cnt;
    int     mismatch_cnt = 0;
    int     fail_cnt = 0;
    string  test_name = "reset";

    tartaruga_fetch_top u_dut (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .instr_valid_o (instr_valid_o),
        .instr_ready_i (instr_ready_i),
        .instr_pc_o    (instr_pc_o),
        .instr_o       (instr_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Memory fill rule, byte address wraps at the memory size.
    function automatic bus32_t mem_word(input bus32_t addr);
        return (addr % MEM_BYTES) + 32'h1000;
    endfunction

    task automatic report_mismatch(input string what, input bus32_t exp, input bus32_t act);
        mismatch_cnt++;
        $display("MISMATCH test=%s check=%s expected=%h actual=%h", test_name, what, exp, act);
    endtask

    task automatic report_failure(input string msg);
        fail_cnt++;
        $display("ERROR in test %s: %s", test_name, msg);
    endtask

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exp_pc        <= '0;
            seen_redirect <= 1'b0;
            accept_cnt    <= 0;
        end else begin
            if (instr_valid_o && instr_ready_i) begin
                accept_cnt <= accept_cnt + 1;
            end
            if (redirect_i) begin
                exp_pc        <= redirect_pc_i;      // Redirect always wins.
                seen_redirect <= 1'b1;
            end else if (instr_valid_o && instr_ready_i) begin
                exp_pc <= exp_pc + 32'd4;
            end
        end
    end

    a_idle_before_redirect: assert property (@(posedge clk) disable iff (!rstn)
        !seen_redirect |-> !instr_valid_o)
        else report_failure("instruction valid before any redirect");

    a_instr_pc: assert property (@(posedge clk) disable iff (!rstn)
        instr_valid_o && instr_ready_i |-> instr_pc_o == exp_pc)
        else report_mismatch("pc", $sampled(exp_pc), $sampled(instr_pc_o));

    a_instr_data: assert property (@(posedge clk) disable iff (!rstn)
        instr_valid_o && instr_ready_i |-> instr_o == mem_word(instr_pc_o))
        else report_mismatch("data", mem_word($sampled(instr_pc_o)), $sampled(instr_o));

    a_hold_stable: assert property (@(posedge clk) disable iff (!rstn)
        instr_valid_o && !instr_ready_i && !redirect_i |=>
            instr_valid_o && $stable(instr_pc_o) && $stable(instr_o))
        else report_failure("held instruction changed or dropped under back-pressure");

    // Consumer side, random stalls once enabled.
    initial begin
        instr_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (random_ready) begin
                instr_ready_i = ($urandom % 4) != 0;
            end else begin
                instr_ready_i = 1'b1;
            end
        end
    end

    task automatic redirect_to(input bus32_t pc);
        @(posedge clk);
        #1;
        redirect_i    = 1'b1;
        redirect_pc_i = pc;
        @(posedge clk);
        #1;
        redirect_i    = 1'b0;
    endtask

    task automatic wait_accepts(input int n);
        int target;
        int cycles;
        int limit;
        target = accept_cnt + n;
        cycles = 0;
        limit  = 30 * n + 50;
        while (accept_cnt < target && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (accept_cnt < target) begin
            report_failure($sformatf("fetch stalled, %0d of %0d instructions in %0d cycles",
                n - (target - accept_cnt), n, limit));
        end
    endtask

    task automatic wait_refill();
        int cycles;
        cycles = 0;
        while (!u_dut.u_line_buf.outstanding_q && cycles < 40) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!u_dut.u_line_buf.outstanding_q) begin
            report_failure("no refill became outstanding");
        end
    endtask

    initial begin
        bus32_t rand_pc;
        int     gap;
        void'($urandom(32'h7a3d_83a0));
        rstn          = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_name = "idle";
        repeat (20) @(posedge clk);

        test_name = "sequential";
        redirect_to(32'h0000_0100);
        wait_accepts(24);

        test_name    = "backpressure";
        random_ready = 1'b1;
        wait_accepts(24);

        test_name = "mid_line";
        redirect_to(32'h0000_0208);
        wait_accepts(1);
        redirect_to(32'h0000_0204);                  // Earlier word of the same line.
        wait_accepts(10);

        test_name = "refill_redirect";
        redirect_to(32'h0000_3000);
        wait_refill();
        redirect_to(32'h0000_0404);
        wait_accepts(12);

        test_name = "random_redirect";
        for (int i = 0; i < 6; i++) begin
            rand_pc = ($urandom % (2 * `IMEM_POS)) * 4;
            gap     = $urandom % 16;
            redirect_to(rand_pc);
            repeat (gap) @(posedge clk);
        end
        wait_accepts(8);

        test_name = "wrap";
        redirect_to(MEM_BYTES - 32'd8);              // Runs across the top of memory.
        wait_accepts(12);
        redirect_to(32'h8000_0010);
        wait_accepts(8);

        $display("Error counts: mismatches=%0d failures=%0d accepted=%0d",
            mismatch_cnt, fail_cnt, accept_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/tartaruga_fetch_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Tartaruga fetch top
// Pc generator, line buffer and instruction memory.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tartaruga_fetch_top
    import tartaruga_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   redirect_i,
    input  bus32_t redirect_pc_i,
    output logic   instr_valid_o,
    input  logic   instr_ready_i,
    output bus32_t instr_pc_o,
    output bus32_t instr_o
);

    logic   pc_valid;
    logic   pc_ready;
    bus32_t pc;

    imem_req_if mem_if ();                           // Refill channel.

    fetch_pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_valid_o    (pc_valid),
        .pc_ready_i    (pc_ready),
        .pc_o          (pc)
    );

    // The redirect also flushes the held instruction.
    fetch_line_buffer u_line_buf (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (redirect_i),
        .pc_valid_i    (pc_valid),
        .pc_ready_o    (pc_ready),
        .pc_i          (pc),
        .instr_valid_o (instr_valid_o),
        .instr_ready_i (instr_ready_i),
        .instr_pc_o    (instr_pc_o),
        .instr_o       (instr_o),
        .mem_if        (mem_if.requester)
    );

    imem_wrapper u_imem (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .mem_if (mem_if.memory)
    );

endmodule

`default_nettype wire

/* verilog/fetch_pc_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Fetch pc generator
// Sequential pc stream, reloaded by a redirect.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen
    import tartaruga_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   redirect_i,
    input  bus32_t redirect_pc_i,
    output logic   pc_valid_o,
    input  logic   pc_ready_i,
    output bus32_t pc_o
);

    logic   armed_q;                                 // Set by the first redirect.
    bus32_t pc_q;

    assign pc_valid_o = armed_q;
    assign pc_o       = pc_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            armed_q <= 1'b0;
            pc_q    <= '0;
        end else if (redirect_i) begin
            // Redirect always wins over a handshake.
            armed_q <= 1'b1;
            pc_q    <= redirect_pc_i;
        end else if (pc_valid_o && pc_ready_i) begin
            pc_q <= pc_q + 32'd4;                    // Next word.
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_line_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Fetch line buffer
// Holds one line, serves words from it, refills on a miss.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "tartaruga_defines.svh"

module fetch_line_buffer
    import tartaruga_pkg::*;
(
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          flush_i,
    input  logic          pc_valid_i,
    output logic          pc_ready_o,
    input  bus32_t        pc_i,
    output logic          instr_valid_o,
    input  logic          instr_ready_i,
    output bus32_t        instr_pc_o,
    output bus32_t        instr_o,
    imem_req_if.requester mem_if
);

    localparam int OFF_W = $clog2(`LINE_WORDS) + 2;   // Byte offset bits in a line.

    lbuf_state_t state_q;
    line128_t    line_q;
    bus32_t      line_addr_q;
    bus32_t      instr_pc_q;                          // Also the pc of a pending miss.
    bus32_t      instr_q;
    bus32_t      exp_addr;
    logic        instr_valid_q;
    logic        req_valid_q;
    logic        outstanding_q;
    logic        discard_q;
    logic        out_free;
    logic        hit;
    logic        pc_fire;
    logic        req_fire;
    logic        rsp_fire;
    logic        addr_ok;

    assign out_free   = ~instr_valid_q | instr_ready_i;
    assign hit        = (state_q == LB_VALID) && (pc_i[31:OFF_W] == line_addr_q[31:OFF_W]);
    assign pc_ready_o = (state_q != LB_REFILL) && out_free && !flush_i;
    assign pc_fire    = pc_valid_i & pc_ready_o;

    assign exp_addr = {instr_pc_q[31:OFF_W], {OFF_W{1'b0}}};
    assign addr_ok  = (mem_if.rsp_addr == exp_addr);

    assign mem_if.req_valid = req_valid_q;
    assign mem_if.req_addr  = exp_addr;               // Stable while in refill.
    assign mem_if.rsp_ready = outstanding_q;
    assign req_fire         = mem_if.req_valid & mem_if.req_ready;
    assign rsp_fire         = mem_if.rsp_valid & mem_if.rsp_ready;

    assign instr_valid_o = instr_valid_q;
    assign instr_pc_o    = instr_pc_q;
    assign instr_o       = instr_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q       <= LB_EMPTY;
            instr_valid_q <= 1'b0;
            req_valid_q   <= 1'b0;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
        end else begin
            if (req_fire) begin
                outstanding_q <= 1'b1;
            end else if (rsp_fire) begin
                outstanding_q <= 1'b0;
            end

            if (out_free || flush_i) begin
                instr_valid_q <= 1'b0;                // Consumed or redirected.
            end

            case (state_q)
                LB_EMPTY, LB_VALID: begin
                    if (pc_fire && hit) begin
                        instr_valid_q <= 1'b1;
                    end else if (pc_fire) begin
                        state_q     <= LB_REFILL;
                        req_valid_q <= 1'b1;
                    end
                end
                LB_REFILL: begin
                    if (req_fire) begin
                        req_valid_q <= 1'b0;
                    end
                    if (flush_i) begin
                        discard_q <= 1'b1;            // Drain the old response.
                    end
                    if (rsp_fire) begin
                        discard_q <= 1'b0;
                        if (discard_q || flush_i) begin
                            state_q <= LB_EMPTY;
                        end else if (addr_ok) begin
                            state_q       <= LB_VALID;
                            instr_valid_q <= 1'b1;
                        end else begin
                            req_valid_q <= 1'b1;      // Wrong line, ask again.
                        end
                    end
                end
                default: state_q <= LB_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (pc_fire) begin
            instr_pc_q <= pc_i;
            instr_q    <= line_q[32*pc_i[OFF_W-1:2] +: 32];
        end
        if (rsp_fire && addr_ok) begin
            line_q      <= mem_if.rsp_line;
            line_addr_q <= mem_if.rsp_addr;
            instr_q     <= mem_if.rsp_line[32*instr_pc_q[OFF_W-1:2] +: 32];
        end
    end

    a_one_refill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        outstanding_q |-> !mem_if.req_valid)
        else $error("second refill issued while one is outstanding");

    a_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_if.req_valid && !mem_if.req_ready |=>
            mem_if.req_valid && $stable(mem_if.req_addr))
        else $error("refill request dropped or changed before transfer");

endmodule

`default_nettype wire

/* verilog/imem_wrapper.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Instruction memory model
// Fixed latency line reads, one request in flight at a time.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "tartaruga_defines.svh"

module imem_wrapper
    import tartaruga_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    imem_req_if.memory mem_if
);

    localparam int LAT   = `IMEM_LAT;
    localparam int IDX_W = $clog2(`IMEM_POS);

    bus32_t           imem [`IMEM_POS];

    logic             req_vld_q  [LAT];              // Request pipeline.
    bus32_t           req_addr_q [LAT];
    logic             dat_vld_q  [LAT];              // Data pipeline, read register first.
    bus32_t           dat_addr_q [LAT];
    line128_t         dat_line_q [LAT];

    logic             busy;
    logic             req_fire;
    logic             rsp_fire;
    logic [IDX_W-1:0] base_idx;
    line128_t         rd_line;

    // Word at byte address A holds A + 0x1000.
    initial begin
        for (int i = 0; i < `IMEM_POS; i++) begin
            imem[i] = bus32_t'(i * 4) + 32'h1000;
        end
    end

    // Only free when nothing is anywhere in the pipeline.
    always_comb begin
        busy = 1'b0;
        for (int i = 0; i < LAT; i++) begin
            busy = busy | req_vld_q[i] | dat_vld_q[i];
        end
    end

    assign mem_if.req_ready = ~busy;
    assign req_fire         = mem_if.req_valid & mem_if.req_ready;
    assign rsp_fire         = mem_if.rsp_valid & mem_if.rsp_ready;

    assign mem_if.rsp_valid = dat_vld_q[LAT-1];
    assign mem_if.rsp_addr  = dat_addr_q[LAT-1];
    assign mem_if.rsp_line  = dat_line_q[LAT-1];

    // Word index wraps modulo the memory depth.
    assign base_idx = req_addr_q[LAT-1][IDX_W+1:2];

    always_comb begin
        for (int k = 0; k < `LINE_WORDS; k++) begin
            rd_line[k*32 +: 32] = imem[base_idx + IDX_W'(k)];
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < LAT; i++) begin
                req_vld_q[i] <= 1'b0;
                dat_vld_q[i] <= 1'b0;
            end
        end else begin
            req_vld_q[0] <= req_fire;
            for (int i = 1; i < LAT; i++) begin
                req_vld_q[i] <= req_vld_q[i-1];
            end

            // Stage 0 empties once stage 1 has room.
            dat_vld_q[0] <= req_vld_q[LAT-1] | (dat_vld_q[0] & dat_vld_q[1]);
            for (int i = 1; i < LAT; i++) begin
                if (!dat_vld_q[i]) begin
                    dat_vld_q[i] <= dat_vld_q[i-1];      // Move into empty slot.
                end
            end
            for (int i = 1; i < LAT - 1; i++) begin
                if (dat_vld_q[i] && !dat_vld_q[i+1]) begin
                    dat_vld_q[i] <= 1'b0;                // Moved on to the next slot.
                end
            end
            if (rsp_fire) begin
                dat_vld_q[LAT-1] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_addr_q[0] <= mem_if.req_addr;
        end
        for (int i = 1; i < LAT; i++) begin
            req_addr_q[i] <= req_addr_q[i-1];
        end

        if (req_vld_q[LAT-1]) begin
            dat_line_q[0] <= rd_line;
            dat_addr_q[0] <= req_addr_q[LAT-1];
        end
        for (int i = 1; i < LAT; i++) begin
            if (!dat_vld_q[i]) begin
                dat_line_q[i] <= dat_line_q[i-1];
                dat_addr_q[i] <= dat_addr_q[i-1];
            end
        end
    end

    // A stalled response must hold its payload.
    a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_if.rsp_valid && !mem_if.rsp_ready |=>
            mem_if.rsp_valid && $stable(mem_if.rsp_line) && $stable(mem_if.rsp_addr))
        else $error("imem response changed while stalled");

endmodule

`default_nettype wire

/* verilog/imem_req_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Line refill channel
// Request and response halves between line buffer and memory.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface imem_req_if
    import tartaruga_pkg::*;
();

    // Request half.
    logic     req_valid;
    logic     req_ready;
    bus32_t   req_addr;                              // Line aligned.

    // Response half.
    logic     rsp_valid;
    logic     rsp_ready;
    bus32_t   rsp_addr;                              // Echo of the request address.
    line128_t rsp_line;

    modport requester (
        output req_valid, req_addr, rsp_ready,
        input  req_ready, rsp_valid, rsp_addr, rsp_line
    );

    modport memory (
        input  req_valid, req_addr, rsp_ready,
        output req_ready, rsp_valid, rsp_addr, rsp_line
    );

endinterface

`default_nettype wire

/* verilog/tartaruga_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Tartaruga package
// Shared types for the fetch front end.
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "tartaruga_defines.svh"

package tartaruga_pkg;

    typedef logic [31:0] bus32_t;                    // Address or instruction word.

    // One fetch line, lowest address in the lowest bits.
    typedef logic [`LINE_WORDS*32-1:0] line128_t;

    typedef enum logic [1:0] {
        LB_EMPTY  = 2'd0,                            // No line held.
        LB_VALID  = 2'd1,                            // Line held and usable.
        LB_REFILL = 2'd2                             // Waiting on memory.
    } lbuf_state_t;

endpackage

`default_nettype wire

/* include/tartaruga_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Tartaruga fetch parameters
// Sizes and latency of the instruction memory and the fetch line.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef TARTARUGA_DEFINES_SVH
`define TARTARUGA_DEFINES_SVH

// Memory depth in 32-bit words.
`define IMEM_POS 4096

// Pipeline depth of the memory request path.
`define IMEM_LAT 5

// Words per instruction line.
`define LINE_WORDS 4

`endif
